// ==== hdl/dbg_params.svh ====
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Host credits, also the request FIFO depth
`define DBG_DMI_CREDITS 4

// Debug CSR numbers reachable through abstract commands
`define DBG_CSR_DCSR 16'h07b0
`define DBG_CSR_DPC  16'h07b1

// DMI register addresses
`define DM_DATA0      7'h04
`define DM_DMCONTROL  7'h10
`define DM_DMSTATUS   7'h11
`define DM_ABSTRACTCS 7'h16
`define DM_COMMAND    7'h17

`endif

// ==== hdl/dm_pkg.sv ====
package dm_pkg;

    ////////////////////////////////////////////////////////////
    // DMI transport
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    typedef struct packed
    {
        logic        valid;
        dmi_op_e     op;
        logic [6:0]  addr;
        logic [31:0] data;
    } dmi_req_t;

    // No ready, the host always takes a response
    typedef struct packed
    {
        logic        valid;
        logic [31:0] data;
    } dmi_rsp_t;

    ////////////////////////////////////////////////////////////
    // Abstract command
    ////////////////////////////////////////////////////////////

    // Encoded as in abstractcs.cmderr
    typedef enum logic [2:0]
    {
        CMDERR_NONE          = 3'd0,
        CMDERR_BUSY          = 3'd1,
        CMDERR_NOT_SUPPORTED = 3'd2,
        CMDERR_HALT_RESUME   = 3'd4
    } cmderr_e;

endpackage : dm_pkg

// ==== hdl/debug_pkg.sv ====
package debug_pkg;

    // Values of dcsr.cause
    typedef enum logic [2:0]
    {
        NO_DBG_CAUSE = 3'd0,
        DBG_EBREAK   = 3'd1,
        DBG_HALTREQ  = 3'd3,
        DBG_STEP     = 3'd4
    } dcause_e;

    typedef enum logic [1:0]
    {
        RUNNING,
        HALTED,
        RESUME
    } core_state_e;

    // Pipeline view supplied from outside
    typedef struct packed
    {
        logic        ebreak_mem;
        logic        no_jump;
        logic        inst_valid_wb;
        logic [31:0] cinst_pc;
        logic [31:0] next_pc_if1;
    } core_trace_t;

    typedef struct packed
    {
        logic running;
        logic halted;
        logic resumeack;
    } core_status_t;

    // One abstract register access
    typedef struct packed
    {
        logic        en;
        logic        wr;
        logic [15:0] addr;
        logic [31:0] data;
    } ar_req_t;

endpackage : debug_pkg

// ==== hdl/dm_regs.sv ====
`timescale 1ns/1ns
`include "dbg_params.svh"

module dm_regs (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  dm_pkg::dmi_req_t        dmi_req_i,
    output dm_pkg::dmi_rsp_t        dmi_rsp_o,
    output logic                    credit_o,
    input  debug_pkg::core_status_t status_i,
    output logic                    haltreq_o,
    output logic                    resumereq_o,
    output logic                    cmd_start_o,
    output logic [31:0]             cmd_o,
    output logic [31:0]             data0_o,
    input  logic                    cmd_busy_i,
    input  logic                    cmd_done_i,
    input  dm_pkg::cmderr_e         cmd_err_i,
    input  logic [31:0]             cmd_rdata_i
);
    import dm_pkg::*;

    localparam int DEPTH = `DBG_DMI_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dmi_req_t         fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fifo_cnt;
    logic             push;
    logic             pop;
    dmi_req_t         head;
    logic             wr_en;
    logic             rd_en;
    logic             cmd_wr;
    logic             busy;

    logic             haltreq_q;
    logic             resumereq_q;
    logic             dmactive_q;
    logic [31:0]      data0_q;
    logic [31:0]      cmd_q;
    cmderr_e          cmderr_q;
    logic             cmd_start_q;

    logic [31:0]      dmcontrol_rd;
    logic [31:0]      dmstatus_rd;
    logic [31:0]      abstractcs_rd;
    logic [31:0]      rdata;
    logic             rsp_valid_q;
    logic [31:0]      rsp_data_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Request FIFO
    ////////////////////////////////////////////////////////////

    // Credits guarantee room for every valid request
    assign push = dmi_req_i.valid;
    assign pop  = (fifo_cnt != '0);
    assign head = fifo_mem[rd_ptr];

    always_ff @(posedge clk_i)
    begin
        if (push)
            fifo_mem[wr_ptr] <= dmi_req_i;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Register updates
    ////////////////////////////////////////////////////////////

    assign wr_en  = pop && (head.op == DMI_WRITE);
    assign rd_en  = pop && (head.op == DMI_READ);
    assign cmd_wr = wr_en && (head.addr == `DM_COMMAND);

    // Start pulse counts as busy before the engine reacts
    assign busy = cmd_busy_i | cmd_start_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            haltreq_q   <= 1'b0;
            resumereq_q <= 1'b0;
            dmactive_q  <= 1'b0;
            cmderr_q    <= CMDERR_NONE;
            cmd_start_q <= 1'b0;
        end
        else
        begin
            cmd_start_q <= cmd_wr && !busy;
            if (wr_en && (head.addr == `DM_DMCONTROL))
            begin
                haltreq_q  <= head.data[31];
                dmactive_q <= head.data[0];
            end
            // Held until the core acknowledges
            if (status_i.resumeack)
                resumereq_q <= 1'b0;
            else if (wr_en && (head.addr == `DM_DMCONTROL) && head.data[30])
                resumereq_q <= 1'b1;
            // First error sticks until written with ones
            if (cmd_done_i && (cmderr_q == CMDERR_NONE))
                cmderr_q <= cmd_err_i;
            else if (cmd_wr && busy && (cmderr_q == CMDERR_NONE))
                cmderr_q <= CMDERR_BUSY;
            else if (wr_en && (head.addr == `DM_ABSTRACTCS))
                cmderr_q <= cmderr_e'(cmderr_q & ~head.data[10:8]);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (cmd_done_i)
            data0_q <= cmd_rdata_i;
        else if (wr_en && (head.addr == `DM_DATA0))
            data0_q <= head.data;
        if (cmd_wr && !busy)
            cmd_q <= head.data;
    end

    ////////////////////////////////////////////////////////////
    // Read path and response
    ////////////////////////////////////////////////////////////

    assign dmcontrol_rd  = {haltreq_q, resumereq_q, 29'd0, dmactive_q};
    // Single hart, so any and all bits match; version 0.13
    assign dmstatus_rd   = {12'd0, 2'b00, {2{status_i.resumeack}}, 4'd0,
                            {2{status_i.running}}, {2{status_i.halted}},
                            1'b1, 3'd0, 4'd2};
    assign abstractcs_rd = {3'd0, 5'd0, 11'd0, busy, 1'b0, cmderr_q, 4'd0, 4'd1};

    always_comb
    begin
        case (head.addr)
            `DM_DATA0:      rdata = data0_q;
            `DM_DMCONTROL:  rdata = dmcontrol_rd;
            `DM_DMSTATUS:   rdata = dmstatus_rd;
            `DM_ABSTRACTCS: rdata = abstractcs_rd;
            default:        rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= pop;
    end

    always_ff @(posedge clk_i)
    begin
        rsp_data_q <= rd_en ? rdata : 32'd0;
    end

    // Credit returns with the response
    assign credit_o    = rsp_valid_q;
    assign dmi_rsp_o   = '{valid: rsp_valid_q, data: rsp_data_q};
    assign haltreq_o   = haltreq_q;
    assign resumereq_o = resumereq_q;
    assign cmd_start_o = cmd_start_q;
    assign cmd_o       = cmd_q;
    assign data0_o     = data0_q;

endmodule : dm_regs

// ==== hdl/dm_abstract_cmd.sv ====
`timescale 1ns/1ns
`include "dbg_params.svh"

module dm_abstract_cmd (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               cmd_start_i,
    input  logic [31:0]        cmd_i,
    input  logic [31:0]        data0_i,
    input  logic               halted_i,
    output logic               busy_o,
    output logic               done_o,
    output dm_pkg::cmderr_e    err_o,
    output logic [31:0]        rdata_o,
    output debug_pkg::ar_req_t ar_o,
    input  logic [31:0]        dcsr_i,
    input  logic [31:0]        dpc_i
);
    import dm_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        CHECK,
        ACCESS
    } cmd_state_e;

    cmd_state_e  state_q;
    cmd_state_e  state_d;
    logic [31:0] cmd_q;
    cmderr_e     err_q;
    cmderr_e     check_err;
    logic [7:0]  cmdtype;
    logic [2:0]  aarsize;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
    logic        regno_ok;
    logic        access_ok;

    // Access register command fields
    assign cmdtype  = cmd_q[31:24];
    assign aarsize  = cmd_q[22:20];
    assign transfer = cmd_q[17];
    assign write    = cmd_q[16];
    assign regno    = cmd_q[15:0];
    assign regno_ok = (regno == `DBG_CSR_DCSR) || (regno == `DBG_CSR_DPC);

    always_comb
    begin
        if (!halted_i)
            check_err = CMDERR_HALT_RESUME;
        else if (cmdtype != 8'd0)
            check_err = CMDERR_NOT_SUPPORTED;
        // Only 32-bit accesses to dcsr and dpc
        else if (transfer && ((aarsize != 3'd2) || !regno_ok))
            check_err = CMDERR_NOT_SUPPORTED;
        else
            check_err = CMDERR_NONE;
    end

    always_comb
    begin
        case (state_q)
            IDLE:    state_d = cmd_start_i ? CHECK : IDLE;
            CHECK:   state_d = ACCESS;
            ACCESS:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
            err_q   <= CMDERR_NONE;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == CHECK)
                err_q <= check_err;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (cmd_start_i && (state_q == IDLE))
            cmd_q <= cmd_i;
    end

    assign access_ok = (state_q == ACCESS) && transfer && (err_q == CMDERR_NONE);

    assign ar_o = '{en: access_ok, wr: write, addr: regno, data: data0_i};

    // data0 keeps its value unless a read succeeded
    assign rdata_o = (access_ok && !write) ?
                     ((regno == `DBG_CSR_DPC) ? dpc_i : dcsr_i) : data0_i;

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == ACCESS);
    assign err_o  = err_q;

endmodule : dm_abstract_cmd

// ==== hdl/core_dbg_fsm.sv ====
`timescale 1ns/1ns
`include "dbg_params.svh"

module core_dbg_fsm (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  debug_pkg::core_trace_t  trace_i,
    input  logic                    haltreq_i,
    input  logic                    resumereq_i,
    input  debug_pkg::ar_req_t      ar_i,
    output debug_pkg::core_status_t status_o,
    output logic [31:0]             dcsr_o,
    output logic [31:0]             dpc_o,
    output logic                    dbg_ret_o
);
    import debug_pkg::*;

    core_state_e state_q;
    core_state_e state_d;
    dcause_e     cause_q;
    logic [31:0] dpc_q;
    logic        ebreakm_q;
    logic [4:0]  dcsr_ctl_q;
    logic        mprven_q;
    logic        step_q;
    logic        running;
    logic        running_q;
    logic        ebreak_hit;
    logic        step_hit;
    logic        halt_go;
    logic        dcsr_wr;
    logic        dpc_wr;

    ////////////////////////////////////////////////////////////
    // Run state
    ////////////////////////////////////////////////////////////

    assign ebreak_hit = trace_i.ebreak_mem && ebreakm_q;
    assign step_hit   = step_q && (!trace_i.no_jump || trace_i.inst_valid_wb);
    assign running    = (state_q == RUNNING);
    assign halt_go    = running && (ebreak_hit || haltreq_i || step_hit);

    always_comb
    begin
        case (state_q)
            RUNNING: state_d = halt_go ? HALTED : RUNNING;
            HALTED:  state_d = resumereq_i ? RESUME : HALTED;
            // Wait for the DM to drop its request
            RESUME:  state_d = resumereq_i ? RESUME : RUNNING;
            default: state_d = RUNNING;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state_q <= RUNNING;
        else
            state_q <= state_d;
    end

    assign status_o = '{running:   running,
                        halted:    (state_q == HALTED) || (state_q == RESUME),
                        resumeack: (state_q == RESUME)};

    ////////////////////////////////////////////////////////////
    // dcsr and dpc
    ////////////////////////////////////////////////////////////

    assign dcsr_wr = ar_i.en && ar_i.wr && (ar_i.addr == `DBG_CSR_DCSR);
    assign dpc_wr  = ar_i.en && ar_i.wr && (ar_i.addr == `DBG_CSR_DPC);

    // Cause priority ebreak, haltreq, step
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            cause_q <= NO_DBG_CAUSE;
        else if (halt_go && ebreak_hit)
            cause_q <= DBG_EBREAK;
        else if (halt_go && haltreq_i)
            cause_q <= DBG_HALTREQ;
        else if (halt_go)
            cause_q <= DBG_STEP;
    end

    // Writable dcsr fields only
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ebreakm_q  <= 1'b0;
            dcsr_ctl_q <= 5'd0;
            mprven_q   <= 1'b0;
            step_q     <= 1'b0;
        end
        else if (dcsr_wr)
        begin
            ebreakm_q  <= ar_i.data[15];
            dcsr_ctl_q <= ar_i.data[13:9];
            mprven_q   <= ar_i.data[4];
            step_q     <= ar_i.data[2];
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            dpc_q <= 32'd0;
        else if (dpc_wr)
            dpc_q <= ar_i.data;
        else if (halt_go)
        begin
            if (ebreak_hit || (step_q && trace_i.inst_valid_wb))
                dpc_q <= trace_i.cinst_pc;
            else if (haltreq_i && trace_i.no_jump)
                dpc_q <= trace_i.cinst_pc;
            // A jump in flight, resume at its target
            else
                dpc_q <= trace_i.next_pc_if1;
        end
    end

    // xdebugver 4, prv fixed at M
    assign dcsr_o = {4'd4, 12'd0, ebreakm_q, 1'b0, dcsr_ctl_q, cause_q,
                     1'b0, mprven_q, 1'b0, step_q, 2'd3};
    assign dpc_o  = dpc_q;

    ////////////////////////////////////////////////////////////
    // Return pulse
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            running_q <= 1'b1;
        else
            running_q <= running;
    end

    assign dbg_ret_o = running && !running_q;

endmodule : core_dbg_fsm

// ==== hdl/dbg_subsystem_top.sv ====
`timescale 1ns/1ns

module dbg_subsystem_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  dm_pkg::dmi_req_t        dmi_req_i,
    output dm_pkg::dmi_rsp_t        dmi_rsp_o,
    output logic                    credit_o,
    input  debug_pkg::core_trace_t  trace_i,
    output debug_pkg::core_status_t status_o,
    output logic                    dbg_ret_o
);
    import dm_pkg::*;
    import debug_pkg::*;

    core_status_t status;
    logic         haltreq;
    logic         resumereq;
    logic         cmd_start;
    logic [31:0]  cmd;
    logic [31:0]  data0;
    logic         cmd_busy;
    logic         cmd_done;
    cmderr_e      cmd_err;
    logic [31:0]  cmd_rdata;
    ar_req_t      ar;
    logic [31:0]  dcsr;
    logic [31:0]  dpc;

    dm_regs i_dm_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .dmi_req_i   (dmi_req_i),
        .dmi_rsp_o   (dmi_rsp_o),
        .credit_o    (credit_o),
        .status_i    (status),
        .haltreq_o   (haltreq),
        .resumereq_o (resumereq),
        .cmd_start_o (cmd_start),
        .cmd_o       (cmd),
        .data0_o     (data0),
        .cmd_busy_i  (cmd_busy),
        .cmd_done_i  (cmd_done),
        .cmd_err_i   (cmd_err),
        .cmd_rdata_i (cmd_rdata)
    );

    dm_abstract_cmd i_dm_abstract_cmd (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_start_i (cmd_start),
        .cmd_i       (cmd),
        .data0_i     (data0),
        .halted_i    (status.halted),
        .busy_o      (cmd_busy),
        .done_o      (cmd_done),
        .err_o       (cmd_err),
        .rdata_o     (cmd_rdata),
        .ar_o        (ar),
        .dcsr_i      (dcsr),
        .dpc_i       (dpc)
    );

    core_dbg_fsm i_core_dbg_fsm (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .trace_i     (trace_i),
        .haltreq_i   (haltreq),
        .resumereq_i (resumereq),
        .ar_i        (ar),
        .status_o    (status),
        .dcsr_o      (dcsr),
        .dpc_o       (dpc),
        .dbg_ret_o   (dbg_ret_o)
    );

    assign status_o = status;

endmodule : dbg_subsystem_top

// ==== testbench/dbg_assertions.sv ====
`timescale 1ns/1ns
`include "dbg_params.svh"

module dbg_assertions (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  dm_pkg::dmi_req_t        dmi_req_i,
    input  logic                    credit_o,
    input  debug_pkg::core_status_t status_i,
    input  logic                    cmd_start_o,
    input  logic                    cmd_busy_i
);

    int outstanding;

    // Requests in flight, one credit each
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(dmi_req_i.valid) - int'(credit_o);
    end

    a_credits: assert property (@(posedge clk_i) disable iff (reset_i)
        outstanding <= `DBG_DMI_CREDITS)
        else $error("more requests outstanding than credits");

    a_run_state: assert property (@(posedge clk_i) disable iff (reset_i)
        !(status_i.halted && status_i.running))
        else $error("core halted and running at once");

    // Check cycle, access cycle, then idle
    a_busy_len: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_start_o |=> cmd_busy_i ##1 cmd_busy_i ##1 !cmd_busy_i)
        else $error("abstract command busy not exactly 2 cycles");

endmodule : dbg_assertions

bind dm_regs dbg_assertions i_dbg_assertions (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dmi_req_i   (dmi_req_i),
    .credit_o    (credit_o),
    .status_i    (status_i),
    .cmd_start_o (cmd_start_o),
    .cmd_busy_i  (cmd_busy_i)
);

// ==== testbench/tb_dbg_subsystem.sv ====
`timescale 1ns/1ns
`include "dbg_params.svh"

module tb_dbg_subsystem;
    import dm_pkg::*;
    import debug_pkg::*;

    localparam int CREDITS    = `DBG_DMI_CREDITS;
    localparam int WAIT_LIMIT = 200;

    logic         clk_i;
    logic         reset_i;
    dmi_req_t     dmi_req;
    dmi_rsp_t     dmi_rsp;
    logic         credit;
    core_trace_t  trace;
    core_status_t status;
    logic         dbg_ret;

    integer       seed = 60768;
    int           sent;
    int           returned;
    int           ret_count;
    int           errors;
    int           tests;
    int           failed_tests;
    logic         ack_seen;
    dmi_rsp_t     rsp_q[$];

    dbg_subsystem_top i_dut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .dmi_req_i (dmi_req),
        .dmi_rsp_o (dmi_rsp),
        .credit_o  (credit),
        .trace_i   (trace),
        .status_o  (status),
        .dbg_ret_o (dbg_ret)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Responses, credits and core events seen mid-cycle
    always @(negedge clk_i)
    begin
        if (!reset_i)
        begin
            if (dmi_rsp.valid)
                rsp_q.push_back(dmi_rsp);
            if (credit)
                returned++;
            if (status.resumeack)
                ack_seen = 1'b1;
            if (dbg_ret)
                ret_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_rsp(input string name, input dmi_rsp_t got, input dmi_rsp_t exp,
                             input logic [31:0] mask);
        if ((got.valid !== exp.valid) || (((got.data ^ exp.data) & mask) !== 32'd0))
        begin
            errors++;
            $display("FAILED t=%0t %s got valid %b data %h exp valid %b data %h mask %h",
                     $time, name, got.valid, got.data, exp.valid, exp.data, mask);
        end
    endtask

    task automatic check_status(input core_status_t got, input core_status_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED t=%0t status_o got %b exp %b", $time, got, exp);
        end
    endtask

    task automatic check_cause(input dcause_e got, input dcause_e exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED t=%0t dcsr.cause got %0d exp %0d", $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("FAILED t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("TEST FAIL");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // DMI host
    ////////////////////////////////////////////////////////////

    task automatic send_req(input dmi_op_e op, input logic [6:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        while (CREDITS - sent + returned <= 0)
        begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("No credit came back from the DUT");
        end
        @(negedge clk_i);
        dmi_req = '{valid: 1'b1, op: op, addr: addr, data: data};
        sent++;
    endtask

    task automatic req_idle();
        int gap;
        @(negedge clk_i);
        dmi_req = '0;
        gap = {$random(seed)} % 3;
        repeat (gap) @(negedge clk_i);
    endtask

    task automatic get_rsp(output dmi_rsp_t r);
        int n;
        n = 0;
        while (rsp_q.size() == 0)
        begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("No DMI response arrived");
        end
        r = rsp_q.pop_front();
    endtask

    task automatic dmi_xfer(input dmi_op_e op, input logic [6:0] addr, input logic [31:0] data,
                            output dmi_rsp_t r);
        send_req(op, addr, data);
        req_idle();
        get_rsp(r);
    endtask

    // Polls abstractcs until busy drops, returns the last read
    task automatic wait_cmd_idle(output dmi_rsp_t r);
        int n;
        n = 0;
        do
        begin
            dmi_xfer(DMI_READ, `DM_ABSTRACTCS, 32'd0, r);
            n++;
            if (n > 20)
                abort_run("Abstract command stayed busy");
        end
        while (r.data[12]);
    endtask

    task automatic run_cmd(input logic [31:0] cmd, input logic [31:0] exp_cs,
                           input logic [31:0] mask);
        dmi_rsp_t r;
        dmi_rsp_t exp;
        dmi_xfer(DMI_WRITE, `DM_COMMAND, cmd, r);
        exp = '{valid: 1'b1, data: 32'd0};
        check_rsp("command write rsp", r, exp, 32'hffffffff);
        wait_cmd_idle(r);
        exp = '{valid: 1'b1, data: exp_cs};
        check_rsp("abstractcs", r, exp, mask);
    endtask

    task automatic wait_core(input logic want_halted);
        int           n;
        core_status_t exp;
        n = 0;
        @(negedge clk_i);
        // A resuming core still shows halted
        while (((want_halted ? status.halted : status.running) !== 1'b1) ||
               (status.resumeack !== 1'b0))
        begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run(want_halted ? "Core never halted" : "Core never ran");
        end
        exp = '{running: !want_halted, halted: want_halted, resumeack: 1'b0};
        check_status(status, exp);
    endtask

    ////////////////////////////////////////////////////////////
    // One line of the case file
    ////////////////////////////////////////////////////////////

    task automatic run_case(input logic [7:0] kind, input logic [31:0] a, input logic [31:0] d,
                            input logic [31:0] e, input logic [31:0] m);
        int       errs0;
        int       n;
        dmi_rsp_t r;
        dmi_rsp_t exp;
        errs0 = errors;
        case (kind)
            "W":
            begin
                dmi_xfer(DMI_WRITE, a[6:0], d, r);
                exp = '{valid: 1'b1, data: 32'd0};
                check_rsp("write rsp", r, exp, m);
            end
            "R":
            begin
                dmi_xfer(DMI_READ, a[6:0], 32'd0, r);
                exp = '{valid: 1'b1, data: e};
                check_rsp("read rsp", r, exp, m);
            end
            "T":
            begin
                @(negedge clk_i);
                trace = '{ebreak_mem: a[0], no_jump: a[1], inst_valid_wb: a[2],
                          cinst_pc: d, next_pc_if1: e};
            end
            "H": wait_core(1'b1);
            "U": wait_core(1'b0);
            "C": run_cmd(d, e, m);
            "M":
            begin
                // Second command lands while the first is busy
                send_req(DMI_WRITE, `DM_COMMAND, d);
                send_req(DMI_WRITE, `DM_COMMAND, d);
                req_idle();
                get_rsp(r);
                get_rsp(r);
                wait_cmd_idle(r);
                exp = '{valid: 1'b1, data: e};
                check_rsp("abstractcs", r, exp, m);
            end
            "K":
            begin
                run_cmd({16'h0022, `DBG_CSR_DCSR}, 32'd0, 32'h700);
                dmi_xfer(DMI_READ, `DM_DATA0, 32'd0, r);
                check_cause(dcause_e'(r.data[8:6]), dcause_e'(e[2:0]));
            end
            "A":
            begin
                n = 0;
                while (!ack_seen)
                begin
                    @(posedge clk_i);
                    n++;
                    if (n > WAIT_LIMIT)
                        abort_run("Core never acknowledged the resume");
                end
                ack_seen = 1'b0;
            end
            "P":
            begin
                @(posedge clk_i);
                check_count("dbg_ret_o pulses", ret_count, e);
                ret_count = 0;
            end
            "B":
            begin
                // Reads and writes alternate so a reordered response shows
                for (int i = 0; i < d; i++)
                    send_req((i % 2) ? DMI_WRITE : DMI_READ, a[6:0], e);
                req_idle();
                for (int i = 0; i < d; i++)
                begin
                    get_rsp(r);
                    exp = '{valid: 1'b1, data: (i % 2) ? 32'd0 : e};
                    check_rsp("burst rsp", r, exp, m);
                end
                repeat (3) @(posedge clk_i);
                check_count("extra responses", rsp_q.size(), 0);
                check_count("credits", CREDITS - sent + returned, CREDITS);
            end
            default:
            begin
                errors++;
                $display("Unknown kind %c in the case file", kind);
            end
        endcase
        tests++;
        if (errors == errs0)
            $display("case %0d (%c) passed", tests, kind);
        else
        begin
            failed_tests++;
            $display("case %0d (%c) failed", tests, kind);
        end
    endtask

    initial
    begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] m;
        reset_i      = 1'b1;
        dmi_req      = '0;
        trace        = '0;
        sent         = 0;
        returned     = 0;
        ret_count    = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        ack_seen     = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        fd = $fopen("testbench/dbg_cases.txt", "r");
        if (fd == 0)
            abort_run("Cannot open testbench/dbg_cases.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if ((line.len() < 2) || (line[0] == "#"))
                    continue;
                n = $sscanf(line, "%c %h %h %h %h", kind, a, d, e, m);
                if (n != 5)
                begin
                    errors++;
                    $display("Malformed line in the case file");
                end
                else
                    run_case(kind, a, d, e, m);
            end
            $fclose(fd);

            $display("%0d cases, %0d failed, %0d errors", tests, failed_tests, errors);
            if (errors == 0)
                $display("TEST PASS");
            else
                $display("TEST FAIL");
            $finish;
        end
    end

    // Last resort against a hung run
    initial
    begin
        #400000;
        $display("Simulation watchdog expired");
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_dbg_subsystem

// ==== testbench/dbg_cases.txt ====
# kind addr data expect mask, hex; T uses addr as flags (0 ebreak, 1 no_jump, 2 wb valid),
# data as cinst_pc, expect as next_pc_if1; C, M compare abstractcs after the command
T 2 80000010 80000014 0
W 10 80000001 0 ffffffff
H 0 0 0 0
R 11 0 00000382 ffffffff
W 10 00000001 0 ffffffff
K 0 0 3 0
R 04 0 400000c3 ffffffff
C 0 002207b1 0 700
R 04 0 80000010 ffffffff
W 04 80001000 0 ffffffff
C 0 002307b1 0 700
W 04 0 0 ffffffff
C 0 002207b1 0 700
R 04 0 80001000 ffffffff
W 04 ffffffff 0 ffffffff
C 0 002307b0 0 700
W 04 0 0 ffffffff
C 0 002207b0 0 700
R 04 0 4000bed7 ffffffff
W 04 00008000 0 ffffffff
C 0 002307b0 0 700
W 10 40000001 0 ffffffff
A 0 0 0 0
U 0 0 0 0
P 0 0 1 0
R 11 0 00000c82 ffffffff
T 3 80000200 80000204 0
H 0 0 0 0
T 0 0 0 0
K 0 0 1 0
C 0 002207b1 0 700
R 04 0 80000200 ffffffff
W 10 40000001 0 ffffffff
A 0 0 0 0
U 0 0 0 0
P 0 0 1 0
T 2 80000280 80000284 0
W 10 80000001 0 ffffffff
H 0 0 0 0
W 10 00000001 0 ffffffff
W 04 00000004 0 ffffffff
C 0 002307b0 0 700
T 6 80000300 80000304 0
W 10 40000001 0 ffffffff
A 0 0 0 0
H 0 0 0 0
P 0 0 1 0
K 0 0 4 0
C 0 002207b1 0 700
R 04 0 80000300 ffffffff
T 0 0 0 0
W 04 0 0 ffffffff
C 0 002307b0 0 700
W 10 40000001 0 ffffffff
A 0 0 0 0
U 0 0 0 0
P 0 0 1 0
C 0 002207b0 400 700
W 16 00000700 0 ffffffff
R 16 0 0 700
T 0 80000400 80000500 0
W 10 80000001 0 ffffffff
H 0 0 0 0
W 10 00000001 0 ffffffff
C 0 002207b1 0 700
R 04 0 80000500 ffffffff
C 0 00221000 200 700
W 16 00000700 0 ffffffff
R 16 0 0 700
M 0 002207b0 100 700
W 16 00000700 0 ffffffff
R 16 0 0 700
W 04 12345678 0 ffffffff
B 04 4 12345678 ffffffff
B 11 4 00000382 ffffffff

// ==== sim.f ====
+incdir+hdl
hdl/dm_pkg.sv
hdl/debug_pkg.sv
hdl/dm_regs.sv
hdl/dm_abstract_cmd.sv
hdl/core_dbg_fsm.sv
hdl/dbg_subsystem_top.sv
testbench/dbg_assertions.sv
testbench/tb_dbg_subsystem.sv

// ==== Bender.yml ====
package:
  name: dbg_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dm_pkg.sv
      - hdl/debug_pkg.sv
      - hdl/dm_regs.sv
      - hdl/dm_abstract_cmd.sv
      - hdl/core_dbg_fsm.sv
      - hdl/dbg_subsystem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/dbg_assertions.sv
      - testbench/tb_dbg_subsystem.sv
